/* vlog.f */
+incdir+design
design/core_pkg.sv
design/fp_pkg.sv
design/ftoi_station.sv
design/ftoi_convert.sv
design/ftoi_unit.sv
tests/ftoi_checker.sv
tests/ftoi_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing
TOP := ftoi_unit_tb
FILELIST := vlog.f
BUILD := obj_dir
LOG := sim.log

SIM := $(BUILD)/V$(TOP)
SRCS := $(wildcard design/*.sv design/*.svh tests/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* tests/ftoi_unit_tb.sv */
`timescale 1ns/10ps
`include "ftoi_consts.svh"

module ftoi_unit_tb;
	localparam int N_TAG = 1 << `FTOI_ROB_WIDTH;
	localparam int WAIT_LIMIT = 1000;

	logic clk;
	logic reset;
	logic issue_valid;
	logic issue_ready;
	core_pkg::ftoi_issue_t issue;
	core_pkg::cdb_t fpr_cdb;
	logic gpr_cdb_valid;
	logic gpr_cdb_ready;
	core_pkg::result_t gpr_cdb;

	logic [31:0] exp_in;
	int test_id;
	logic [N_TAG-1:0] pending;
	int chk_errors;
	int chk_results;
	int chk_overtakes;

	int errors;
	int err_base;
	int chk_base;
	int stall_count;
	logic bp_on;
	int bp_run;

	// producer broadcasts still to be sent.
	core_pkg::rob_tag_t prod_tag [$];
	logic [31:0] prod_data [$];
	int prod_delay [$];

	ftoi_unit ftoi_unit_inst (
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_valid),
		.issue_ready(issue_ready),
		.issue(issue),
		.fpr_cdb(fpr_cdb),
		.gpr_cdb_valid(gpr_cdb_valid),
		.gpr_cdb_ready(gpr_cdb_ready),
		.gpr_cdb(gpr_cdb)
	);

	ftoi_checker ftoi_checker_inst (
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_valid),
		.issue_ready(issue_ready),
		.issue(issue),
		.exp_in(exp_in),
		.gpr_cdb_valid(gpr_cdb_valid),
		.gpr_cdb_ready(gpr_cdb_ready),
		.gpr_cdb(gpr_cdb),
		.test_id(test_id),
		.pending(pending),
		.errors(chk_errors),
		.results(chk_results),
		.overtakes(chk_overtakes)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		if (reset) begin
			stall_count <= 0;
		end else if (issue_valid && !issue_ready) begin
			stall_count <= stall_count + 1;
		end
	end

	// round to nearest even, saturate, nan to the most positive value.
	function automatic logic [31:0] ftoi_ref(input logic [31:0] x);
		int e;
		int shift;
		logic [63:0] m;
		logic [63:0] q;
		logic [63:0] rem;
		logic [63:0] half;
		e = int'(x[30:23]) - 127;
		if (x[30:23] == 8'hff && x[22:0] != 23'd0) begin
			return 32'h7fff_ffff;
		end
		if (x[30:23] == 8'hff || e >= 31) begin
			return x[31] ? 32'h8000_0000 : 32'h7fff_ffff;
		end
		if (x[30:23] == 8'h00) begin
			return 32'd0; // zero and denormals.
		end
		m = {40'd0, 1'b1, x[22:0]};
		if (e >= 23) begin
			q = m << (e - 23);
		end else begin
			shift = 23 - e;
			if (shift > 25) begin
				q = 64'd0;
			end else begin
				q = m >> shift;
				rem = m & ((64'd1 << shift) - 64'd1);
				half = 64'd1 << (shift - 1);
				if (rem > half || (rem == half && q[0])) begin
					q = q + 64'd1;
				end
			end
		end
		return x[31] ? -q[31:0] : q[31:0];
	endfunction

	// in-range value with about a third exact ties.
	function automatic logic [31:0] rand_in_range();
		int e;
		int shift;
		logic [22:0] m;
		e = int'($urandom % 41) - 10;
		m = 23'($urandom);
		if ($urandom % 3 == 0 && e >= 0 && e <= 22) begin
			shift = 23 - e;
			m = m & ~((23'd1 << shift) - 23'd1);
			m = m | (23'd1 << (shift - 1));
		end
		return {1'($urandom), 8'(e + 127), m};
	endfunction

	function automatic logic pick_tag(output core_pkg::rob_tag_t tag);
		int start;
		int t;
		start = int'($urandom % N_TAG);
		tag = '0;
		for (int k = 0; k < N_TAG; k++) begin
			t = (start + k) % N_TAG;
			if (!pending[t]) begin
				tag = core_pkg::rob_tag_t'(t);
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	// producer tag not waiting and not on the bus right now.
	function automatic core_pkg::rob_tag_t fresh_prod();
		core_pkg::rob_tag_t t;
		logic used;
		used = 1'b1;
		t = '0;
		while (used) begin
			t = core_pkg::rob_tag_t'($urandom);
			used = fpr_cdb.valid && fpr_cdb.tag == t;
			foreach (prod_tag[i]) begin
				if (prod_tag[i] == t) used = 1'b1;
			end
		end
		return t;
	endfunction

	task automatic cdb_step();
		int due;
		due = -1;
		fpr_cdb = '0;
		foreach (prod_delay[i]) begin
			if (due < 0 && prod_delay[i] <= 0) begin
				due = i;
			end else begin
				prod_delay[i] = prod_delay[i] - 1;
			end
		end
		if (due >= 0) begin
			fpr_cdb.valid = 1'b1;
			fpr_cdb.tag = prod_tag[due];
			fpr_cdb.data = prod_data[due];
			prod_tag.delete(due);
			prod_data.delete(due);
			prod_delay.delete(due);
		end
	endtask

	task automatic tick();
		@(negedge clk);
		cdb_step();
		if (!bp_on) begin
			gpr_cdb_ready = 1'b1;
		end else begin
			if (bp_run <= 0) begin
				gpr_cdb_ready = ($urandom % 5) < 2;
				bp_run = 1 + int'($urandom % 12);
			end
			bp_run = bp_run - 1;
		end
	endtask

	// mode 0 ready operand, 1 later broadcast, 2 broadcast on the accepting edge.
	task automatic issue_one(input logic [31:0] val, input int mode);
		core_pkg::rob_tag_t dest;
		core_pkg::rob_tag_t prod;
		int waited;
		logic acc;
		waited = 0;
		while (!pick_tag(dest)) begin
			tick();
			waited++;
			if (waited > WAIT_LIMIT) begin
				$display("test %0d: no destination tag came free", test_id);
				errors++;
				return;
			end
		end
		prod = (mode == 0) ? core_pkg::rob_tag_t'($urandom) : fresh_prod();
		issue.dest = dest;
		issue.opd.ready = (mode == 0);
		issue.opd.tag = prod;
		issue.opd.data = (mode == 0) ? val : $urandom;
		exp_in = ftoi_ref(val);
		issue_valid = 1'b1;
		if (mode == 2) begin
			prod_tag.push_back(prod);
			prod_data.push_back(val);
			prod_delay.push_back(0);
			cdb_step();
		end
		acc = 1'b0;
		waited = 0;
		while (!acc) begin
			@(posedge clk);
			acc = issue_ready;
			tick();
			waited++;
			if (!acc && waited > WAIT_LIMIT) begin
				$display("test %0d: issue for tag %0d was never accepted", test_id, dest);
				errors++;
				issue_valid = 1'b0;
				return;
			end
		end
		issue_valid = 1'b0;
		if (mode == 1) begin
			prod_tag.push_back(prod);
			prod_data.push_back(val);
			prod_delay.push_back(1 + int'($urandom % 8));
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (pending != '0 || prod_tag.size() != 0) begin
			tick();
			waited++;
			if (waited > WAIT_LIMIT) begin
				$display("test %0d: results missing at the end for tags %b", test_id, pending);
				errors++;
				break;
			end
		end
	endtask

	task automatic begin_test(input int id);
		test_id = id;
		err_base = errors;
		chk_base = chk_errors;
	endtask

	task automatic end_test(input string name);
		$display("test %0d %s: %0d errors", test_id, name,
			(errors - err_base) + (chk_errors - chk_base));
	endtask

	initial begin
		logic [31:0] specials [16];
		int stall_base;
		int overtake_base;
		void'($urandom(32'h8382_81fb));
		specials = '{32'h7fc0_0000, 32'hffc0_0001, 32'h7f80_0000, 32'hff80_0000,
			32'h4f00_0000, 32'hcf00_0000, 32'h4f80_0000, 32'hcf80_0000,
			32'h8000_0000, 32'h3e80_0000, 32'hbf00_0000, 32'h3f00_0000,
			32'h3fc0_0000, 32'h4020_0000, 32'h4eff_ffff, 32'h0000_0001};
		reset = 1'b1;
		issue_valid = 1'b0;
		issue = '0;
		fpr_cdb = '0;
		gpr_cdb_ready = 1'b1;
		exp_in = '0;
		test_id = 0;
		errors = 0;
		bp_on = 1'b0;
		bp_run = 0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		tick();

		begin_test(1);
		for (int i = 0; i < 20; i++) begin
			tick();
			if (!issue_ready) begin
				$display("test 1: issue_ready was low after reset");
				errors++;
			end
			if (gpr_cdb_valid) begin
				$display("test 1: gpr_cdb_valid went high with nothing issued");
				errors++;
			end
		end
		end_test("reset_state");

		begin_test(2);
		for (int i = 0; i < 60; i++) issue_one(rand_in_range(), 0);
		drain();
		end_test("ready_operands");

		begin_test(3);
		overtake_base = chk_overtakes;
		for (int i = 0; i < 40; i++) issue_one(rand_in_range(), int'($urandom % 2));
		drain();
		if (chk_overtakes == overtake_base) begin
			$display("test 3: no ready entry ever passed an older waiting entry");
			errors++;
		end
		end_test("delayed_wakeup");

		begin_test(4);
		for (int i = 0; i < 10; i++) begin
			drain();
			issue_one(rand_in_range(), 2);
		end
		drain();
		end_test("same_cycle_wakeup");

		begin_test(5);
		foreach (specials[i]) issue_one(specials[i], 0);
		drain();
		end_test("special_values");

		begin_test(6);
		stall_base = stall_count;
		bp_on = 1'b1;
		for (int i = 0; i < 50; i++) issue_one(rand_in_range(), int'($urandom % 2));
		drain();
		bp_on = 1'b0;
		tick();
		if (stall_count == stall_base) begin
			$display("test 6: issue_ready never fell while the station was full");
			errors++;
		end
		end_test("back_pressure");

		$display("tests 6, results %0d, errors %0d", chk_results, errors + chk_errors);
		if (errors + chk_errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

/* tests/ftoi_checker.sv */
`timescale 1ns/10ps
`include "ftoi_consts.svh"

module ftoi_checker (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	input logic issue_ready,
	input core_pkg::ftoi_issue_t issue,
	input logic [31:0] exp_in,
	input logic gpr_cdb_valid,
	input logic gpr_cdb_ready,
	input core_pkg::result_t gpr_cdb,
	input int test_id,
	output logic [(1 << `FTOI_ROB_WIDTH)-1:0] pending,
	output int errors,
	output int results,
	output int overtakes
);
	localparam int N_TAG = 1 << `FTOI_ROB_WIDTH;

	logic [31:0] expected [N_TAG]; // indexed by destination tag.
	int issue_seq [N_TAG]; // issue order by destination tag.
	int next_seq;
	logic stalled;
	core_pkg::result_t stalled_cdb;

	function automatic string test_name(input int id);
		case (id)
			1: return "reset_state";
			2: return "ready_operands";
			3: return "delayed_wakeup";
			4: return "same_cycle_wakeup";
			5: return "special_values";
			6: return "back_pressure";
			default: return "idle";
		endcase
	endfunction

	// an older issue still waiting means this one passed it in the station.
	function automatic logic older_pending(input core_pkg::rob_tag_t tag);
		for (int t = 0; t < N_TAG; t++) begin
			if (pending[t] && issue_seq[t] < issue_seq[tag]) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	always @(posedge clk) begin
		int bad;
		bad = 0;
		if (reset) begin
			pending <= '0;
			errors <= 0;
			results <= 0;
			overtakes <= 0;
			next_seq <= 0;
			stalled <= 1'b0;
		end else begin
			if (stalled && (!gpr_cdb_valid || gpr_cdb !== stalled_cdb)) begin
				$display("%s: gpr_cdb changed before it was accepted",
					test_name(test_id));
				bad++;
			end
			stalled <= gpr_cdb_valid && !gpr_cdb_ready;
			stalled_cdb <= gpr_cdb;
			if (gpr_cdb_valid && gpr_cdb_ready) begin
				results <= results + 1;
				if (!pending[gpr_cdb.tag]) begin
					$display("%s: result for tag %0d that was not expected",
						test_name(test_id), gpr_cdb.tag);
					bad++;
				end else begin
					pending[gpr_cdb.tag] <= 1'b0; // tag goes back to the pool.
					if (older_pending(gpr_cdb.tag)) begin
						overtakes <= overtakes + 1;
					end
					if (gpr_cdb.data !== expected[gpr_cdb.tag]) begin
						$display("Mismatch in %s: tag %0d expected %h actual %h",
							test_name(test_id), gpr_cdb.tag,
							expected[gpr_cdb.tag], gpr_cdb.data);
						bad++;
					end
				end
			end
			if (issue_valid && issue_ready) begin
				pending[issue.dest] <= 1'b1;
				expected[issue.dest] <= exp_in;
				issue_seq[issue.dest] <= next_seq;
				next_seq <= next_seq + 1;
			end
			errors <= errors + bad;
		end
	end

endmodule

/* design/ftoi_unit.sv */
`timescale 1ns/10ps

module ftoi_unit (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	output logic issue_ready,
	input core_pkg::ftoi_issue_t issue,
	input core_pkg::cdb_t fpr_cdb,
	output logic gpr_cdb_valid,
	input logic gpr_cdb_ready,
	output core_pkg::result_t gpr_cdb
);
	// station to converter.
	logic disp_valid;
	logic disp_ready;
	core_pkg::result_t disp;

	ftoi_station ftoi_station_inst (
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_valid),
		.issue_ready(issue_ready),
		.issue(issue),
		.fpr_cdb(fpr_cdb),
		.disp_valid(disp_valid),
		.disp_ready(disp_ready),
		.disp(disp)
	);

	ftoi_convert ftoi_convert_inst (
		.clk(clk),
		.reset(reset),
		.disp_valid(disp_valid),
		.disp_ready(disp_ready),
		.disp(disp),
		.gpr_cdb_valid(gpr_cdb_valid),
		.gpr_cdb_ready(gpr_cdb_ready),
		.gpr_cdb(gpr_cdb)
	);

endmodule

/* design/ftoi_convert.sv */
`timescale 1ns/10ps

module ftoi_convert (
	input logic clk,
	input logic reset,
	input logic disp_valid,
	output logic disp_ready,
	input core_pkg::result_t disp,
	output logic gpr_cdb_valid,
	input logic gpr_cdb_ready,
	output core_pkg::result_t gpr_cdb
);
	localparam int FRAC_W = 32; // fraction bits of the aligned value.
	localparam logic signed [9:0] BIAS = 10'sd127;
	localparam logic signed [9:0] ALIGN_OFS = 10'(FRAC_W - fp_pkg::FP32_MANT_W);
	localparam logic signed [9:0] MIN_EXP = -ALIGN_OFS;
	localparam logic signed [9:0] SAT_EXP = 10'sd31;
	localparam logic [31:0] INT_MAX = 32'h7fff_ffff;
	localparam logic [31:0] INT_MIN = 32'h8000_0000;

	// aligned magnitude with rounding bits.
	typedef struct packed {
		core_pkg::rob_tag_t tag;
		logic sign;
		logic nan;
		logic sat;           // infinity or |x| >= 2^31.
		logic [31:0] mag;
		logic guard;
		logic sticky;
	} align_t;

	fp_pkg::fp32_u word;
	logic signed [9:0] uexp;
	logic [23:0] sig;
	logic [5:0] shamt;
	logic [2*FRAC_W-1:0] fixed;
	align_t s1_in;
	align_t s1;
	logic s1_valid;

	logic round_up;
	logic [31:0] mag_r;
	core_pkg::result_t s2_in;
	core_pkg::result_t s2;
	logic s2_valid;

	core_pkg::result_t hold;
	logic hold_valid;

	logic take;
	logic s2_go;
	logic s2_free;
	logic s1_go;

	assign word.raw = disp.data;

	// stage 1 classifies and aligns.
	always_comb begin
		sig = {word.f.exp != 8'd0, word.f.mant}; // denormals read as zero.
		uexp = $signed({2'b00, word.f.exp}) - BIAS;
		shamt = 6'(uexp + ALIGN_OFS);
		fixed = (2*FRAC_W)'(sig) << shamt;
		s1_in.tag = disp.tag;
		s1_in.sign = word.f.sign;
		s1_in.nan = (word.f.exp == 8'hff) && (word.f.mant != '0);
		s1_in.sat = !s1_in.nan && (uexp >= SAT_EXP);
		if (uexp < MIN_EXP) begin
			s1_in.mag = '0; // below 2^-9.
			s1_in.guard = 1'b0;
			s1_in.sticky = |sig;
		end else begin
			s1_in.mag = fixed[2*FRAC_W-1:FRAC_W];
			s1_in.guard = fixed[FRAC_W-1];
			s1_in.sticky = |fixed[FRAC_W-2:0];
		end
	end

	// stage 2 rounds to nearest even, applies the sign and saturates.
	always_comb begin
		round_up = s1.guard && (s1.sticky || s1.mag[0]);
		mag_r = s1.mag + 32'(round_up);
		s2_in.tag = s1.tag;
		if (s1.nan) begin
			s2_in.data = INT_MAX;
		end else if (s1.sat) begin
			s2_in.data = s1.sign ? INT_MIN : INT_MAX;
		end else begin
			s2_in.data = s1.sign ? -mag_r : mag_r;
		end
	end

	// hold slot is older than s2 and drives the bus first.
	assign gpr_cdb_valid = hold_valid || s2_valid;
	assign gpr_cdb = hold_valid ? hold : s2;
	assign take = gpr_cdb_valid && gpr_cdb_ready;

	assign s2_go = s2_valid && (!hold_valid || take);
	assign s2_free = !s2_valid || s2_go;
	assign s1_go = s1_valid && s2_free;
	assign disp_ready = !s1_valid || s1_go;

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			hold_valid <= 1'b0;
		end else begin
			if (disp_ready) begin
				s1_valid <= disp_valid;
			end
			if (s2_free) begin
				s2_valid <= s1_valid;
			end
			if (hold_valid) begin
				if (take) begin
					hold_valid <= s2_valid;
				end
			end else begin
				hold_valid <= s2_valid && !gpr_cdb_ready; // park stalled s2.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (disp_ready) begin
			s1 <= s1_in;
		end
		if (s2_free) begin
			s2 <= s2_in;
		end
		if (!hold_valid || take) begin
			hold <= s2;
		end
	end

endmodule

/* design/ftoi_station.sv */
`timescale 1ns/10ps
`include "ftoi_consts.svh"

module ftoi_station (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	output logic issue_ready,
	input core_pkg::ftoi_issue_t issue,
	input core_pkg::cdb_t fpr_cdb,
	output logic disp_valid,
	input logic disp_ready,
	output core_pkg::result_t disp
);
	localparam int N = `FTOI_N_ENTRY;
	localparam int SEL_W = $clog2(N);

	// entries kept oldest first, compacted towards index 0.
	logic [N-1:0] ent_valid;
	core_pkg::ftoi_issue_t ent [N];

	// stored entries after cdb capture with slot N always empty.
	logic [N:0] woken_valid;
	core_pkg::ftoi_issue_t woken [N+1];

	core_pkg::ftoi_issue_t arriving;
	logic [N-1:0] ent_valid_next;
	core_pkg::ftoi_issue_t ent_next [N];

	logic [SEL_W-1:0] sel;
	logic dispatch;
	logic accept;

	// capture a broadcast for an operand still waiting on it.
	function automatic core_pkg::opd_t wake(input core_pkg::opd_t opd,
		input core_pkg::cdb_t cdb);
		core_pkg::opd_t res;
		res = opd;
		if (!opd.ready && cdb.valid && cdb.tag == opd.tag) begin
			res.ready = 1'b1;
			res.data = cdb.data;
		end
		return res;
	endfunction

	always_comb begin
		arriving = issue;
		arriving.opd = wake(issue.opd, fpr_cdb); // same-cycle broadcast.
	end

	always_comb begin
		for (int i = 0; i < N; i++) begin
			woken_valid[i] = ent_valid[i];
			woken[i] = ent[i];
			woken[i].opd = wake(ent[i].opd, fpr_cdb);
		end
		woken_valid[N] = 1'b0;
		woken[N] = '0;
	end

	// oldest entry whose operand was ready at the last edge.
	always_comb begin
		disp_valid = 1'b0;
		sel = '0;
		for (int i = N - 1; i >= 0; i--) begin
			if (ent_valid[i] && ent[i].opd.ready) begin
				disp_valid = 1'b1;
				sel = SEL_W'(i);
			end
		end
	end

	assign disp.tag = ent[sel].dest;
	assign disp.data = ent[sel].opd.data;

	assign dispatch = disp_valid && disp_ready;
	assign issue_ready = !ent_valid[N-1] || dispatch;
	assign accept = issue_valid && issue_ready;

	// close the gap left by dispatch, then append behind the survivors.
	always_comb begin
		logic placed;
		placed = 1'b0;
		for (int i = 0; i < N; i++) begin
			if (dispatch && i >= int'(sel)) begin
				ent_valid_next[i] = woken_valid[i+1];
				ent_next[i] = woken[i+1];
			end else begin
				ent_valid_next[i] = woken_valid[i];
				ent_next[i] = woken[i];
			end
			if (!ent_valid_next[i] && accept && !placed) begin
				ent_valid_next[i] = 1'b1;
				ent_next[i] = arriving;
				placed = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ent_valid <= '0;
		end else begin
			ent_valid <= ent_valid_next;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < N; i++) begin
			ent[i] <= ent_next[i];
		end
	end

endmodule

/* design/fp_pkg.sv */
package fp_pkg;

	localparam int FP32_EXP_W = 8;
	localparam int FP32_MANT_W = 23;

	// ieee-754 single precision fields.
	typedef struct packed {
		logic sign;
		logic [FP32_EXP_W-1:0] exp;
		logic [FP32_MANT_W-1:0] mant;
	} fp32_fields_t;

	// same word moved as raw bits or decoded as fields.
	typedef union packed {
		logic [31:0] raw;
		fp32_fields_t f;
	} fp32_u;

endpackage

/* design/core_pkg.sv */
`include "ftoi_consts.svh"

package core_pkg;

	typedef logic [`FTOI_ROB_WIDTH-1:0] rob_tag_t;

	// one broadcast on a common data bus.
	typedef struct packed {
		logic valid;
		rob_tag_t tag;
		logic [31:0] data;
	} cdb_t;

	typedef struct packed {
		logic ready;       // data present.
		rob_tag_t tag;     // producer while not ready.
		logic [31:0] data;
	} opd_t;

	typedef struct packed {
		rob_tag_t dest;
		opd_t opd;
	} ftoi_issue_t;

	// cdb payload without the valid bit.
	typedef struct packed {
		rob_tag_t tag;
		logic [31:0] data;
	} result_t;

endpackage

/* design/ftoi_consts.svh */
`ifndef FTOI_CONSTS_SVH
`define FTOI_CONSTS_SVH

// reorder-buffer tag width.
`define FTOI_ROB_WIDTH 4

// reservation station depth of 2 or more.
`define FTOI_N_ENTRY 2

`endif
